//--- project.f
+incdir+include
logic/aes_state_pkg.sv
logic/aes_key_pkg.sv
logic/aes_sbox_bank.sv
logic/aes_mix_columns.sv
logic/aes_key_schedule.sv
logic/aes_enc_round.sv
logic/aes_enc_core.sv
verification/aes_enc_tb.sv

//--- Bender.yml
package:
  name: aes_enc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/aes_state_pkg.sv
      - logic/aes_key_pkg.sv
      - logic/aes_sbox_bank.sv
      - logic/aes_mix_columns.sv
      - logic/aes_key_schedule.sv
      - logic/aes_enc_round.sv
      - logic/aes_enc_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/aes_enc_tb.sv

//--- verification/aes_enc_tb.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_enc_tb;

    logic                    clk;
    logic                    resetn;
    logic                    start;
    aes_state_pkg::state_t   plaintext;
    aes_key_pkg::round_key_t key;
    aes_state_pkg::state_t   ciphertext;
    logic                    busy;
    logic                    done;

    // what the checkers expect right now
    string                   test_name;
    aes_state_pkg::state_t   exp_ct;
    // last finished result, must sit on ciphertext between done pulses
    aes_state_pkg::state_t   held_ct;
    // a run was started and its done not yet consumed
    logic                    run_open;
    integer                  seed;

    // appendix C.1 vector
    localparam logic [127:0] fips_key = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] fips_pt  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] fips_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    // forward S-box, one row per high nibble
    localparam logic [127:0] sbox_rows [16] = '{
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    aes_enc_core UUT (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .busy       (busy),
        .done       (done)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // low nibble picks the byte inside the row
    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sbox_rows[b[7:4]][127 - 8*int'(b[3:0]) -: 8];
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? `AES_GF_REDUCE : 8'h00);
    endfunction

    // straight FIPS-197 cipher, full key expansion up front
    function automatic logic [127:0] encrypt_block(input logic [127:0] pt, input logic [127:0] k);
        logic [31:0]  w [44];
        logic [31:0]  temp;
        logic [7:0]   rcon;
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   all;
        logic [127:0] blk;
        rcon = 8'h01;
        for (int i = 0; i < 4; i++)
        begin
            w[i] = k[127 - 32*i -: 32];
        end
        for (int i = 4; i < 44; i++)
        begin
            temp = w[i-1];
            if (i % 4 == 0)
            begin
                // RotWord then SubWord, rcon into the first byte
                temp = {sbox(temp[23:16]), sbox(temp[15:8]), sbox(temp[7:0]), sbox(temp[31:24])};
                temp = temp ^ {rcon, 24'h000000};
                rcon = xtime(rcon);
            end
            w[i] = w[i-4] ^ temp;
        end
        blk = pt ^ k;
        for (int r = 1; r <= `AES_NUM_ROUNDS; r++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                s[i] = sbox(blk[127 - 8*i -: 8]);
            end
            // s[4c + r] is row r of column c
            for (int c = 0; c < 4; c++)
            begin
                for (int row = 0; row < 4; row++)
                begin
                    t[4*c + row] = s[4*((c + row) % 4) + row];
                end
            end
            if (r < `AES_NUM_ROUNDS)
            begin
                for (int c = 0; c < 4; c++)
                begin
                    all = t[4*c] ^ t[4*c+1] ^ t[4*c+2] ^ t[4*c+3];
                    s[0] = t[4*c];
                    t[4*c]   = t[4*c]   ^ all ^ xtime(t[4*c]   ^ t[4*c+1]);
                    t[4*c+1] = t[4*c+1] ^ all ^ xtime(t[4*c+1] ^ t[4*c+2]);
                    t[4*c+2] = t[4*c+2] ^ all ^ xtime(t[4*c+2] ^ t[4*c+3]);
                    // first byte already overwritten, use the saved copy
                    t[4*c+3] = t[4*c+3] ^ all ^ xtime(t[4*c+3] ^ s[0]);
                end
            end
            for (int i = 0; i < 16; i++)
            begin
                blk[127 - 8*i -: 8] = t[i];
            end
            blk = blk ^ {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
        end
        return blk;
    endfunction

    function automatic logic [127:0] random_block();
        logic [127:0] v;
        for (int i = 0; i < 4; i++)
        begin
            v[32*i +: 32] = $random(seed);
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("Error in %s: %s", test_name, what);
        abort_run();
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            step_cycle();
        end
    endtask

    task automatic launch_block(input logic [127:0] pt, input logic [127:0] k,
                                input logic [127:0] expected);
        exp_ct    = expected;
        run_open  = 1'b1;
        plaintext = pt;
        key       = k;
        start     = 1'b1;
        step_cycle();
        start     = 1'b0;
    endtask

    // bounded wait, then one more edge so the result check sees exp_ct
    task automatic complete_block();
        int cycles;
        cycles = 0;
        while (!done)
        begin
            if (cycles == 40)
            begin
                report_error("done strobe never came after start");
            end
            step_cycle();
            cycles++;
        end
        held_ct = exp_ct;
        step_cycle();
        run_open = 1'b0;
    endtask

    task automatic run_block(input logic [127:0] pt, input logic [127:0] k,
                             input logic [127:0] expected);
        launch_block(pt, k, expected);
        complete_block();
    endtask

    // result lands with done
    a_result: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (ciphertext == exp_ct))
        else report_mismatch(test_name, exp_ct, $sampled(ciphertext));

    // busy for ten samples, then done and busy low together
    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        (start && !busy) |=> (busy && !done) [*`AES_NUM_ROUNDS] ##1 (done && !busy))
        else report_error("done did not come 11 cycles after start, or busy dropped early");

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else report_error("done stayed high for more than one cycle");

    // output register only moves on done
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        !done |-> (ciphertext == held_ct))
        else report_mismatch({test_name, "_hold"}, held_ct, $sampled(ciphertext));

    // no stray activity, catches a second done or a run after abort
    a_idle: assert property (@(posedge clk) disable iff (!resetn)
        !run_open |-> (!busy && !done))
        else report_error("busy or done seen with no run pending");

    a_reset_values: assert property (@(posedge clk)
        $rose(resetn) |-> (!busy && !done && (ciphertext == '0)))
        else report_error("busy, done or ciphertext not cleared by reset");

    initial
    begin
        logic [127:0] pt;
        logic [127:0] k;
        logic [127:0] model_ct;
        clk       = 1'b0;
        resetn    = 1'b0;
        start     = 1'b0;
        plaintext = '0;
        key       = '0;
        seed      = 32'h2035_facc;
        test_name = "power_on_reset";
        exp_ct    = '0;
        held_ct   = '0;
        run_open  = 1'b0;
        idle_cycles(2);
        resetn = 1'b1;

        // model against the published vector first
        test_name = "fips_vector";
        model_ct = encrypt_block(fips_pt, fips_key);
        assert (model_ct == fips_ct)
            else report_mismatch("reference_model", fips_ct, model_ct);
        run_block(fips_pt, fips_key, fips_ct);

        // back to back, so hold is checked across every run
        for (int n = 0; n < 20; n++)
        begin
            test_name = $sformatf("random_%0d", n);
            pt = random_block();
            k  = random_block();
            run_block(pt, k, encrypt_block(pt, k));
        end

        // second start mid-run with other data
        test_name = "ignored_start";
        pt = random_block();
        k  = random_block();
        launch_block(pt, k, encrypt_block(pt, k));
        idle_cycles(3);
        plaintext = ~pt;
        key       = ~k;
        start     = 1'b1;
        step_cycle();
        start     = 1'b0;
        complete_block();
        idle_cycles(15);

        // abort a run, nothing may come out of it
        test_name = "mid_run_reset";
        pt = random_block();
        k  = random_block();
        launch_block(pt, k, encrypt_block(pt, k));
        idle_cycles(4);
        resetn   = 1'b0;
        run_open = 1'b0;
        held_ct  = '0;
        idle_cycles(2);
        resetn = 1'b1;
        idle_cycles(15);

        test_name = "after_reset";
        pt = random_block();
        k  = random_block();
        run_block(pt, k, encrypt_block(pt, k));

        $display("test passed");
        $finish;
    end

endmodule

//--- logic/aes_enc_core.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_enc_core (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  aes_state_pkg::state_t   plaintext,
    input  aes_key_pkg::round_key_t key,
    output aes_state_pkg::state_t   ciphertext,
    output logic                    busy,
    output logic                    done
);

    // working state between rounds
    aes_state_pkg::state_t   state_reg;
    aes_state_pkg::state_t   round_out;
    // key for the round about to be applied
    aes_key_pkg::round_key_t round_key;
    // round applied on the next edge, 0 when idle
    aes_key_pkg::round_idx_t round_cnt;

    logic load;
    logic advance;
    logic last_round;

    // start only counts when idle
    assign load = start && !busy;

    assign last_round = (round_cnt == `AES_NUM_ROUNDS);

    // no key step after the final round
    assign advance = busy && !last_round;

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .key       (key),
        .advance   (advance),
        .round_key (round_key)
    );

    aes_enc_round u_enc_round (
        .state_in   (state_reg),
        .round_key  (round_key),
        .last_round (last_round),
        .state_out  (round_out)
    );

    // run control and the output register
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            busy       <= 1'b0;
            done       <= 1'b0;
            round_cnt  <= '0;
            ciphertext <= '0;
        end
        else
        begin
            // done is a single pulse
            done <= 1'b0;
            if (load)
            begin
                busy      <= 1'b1;
                round_cnt <= 4'd1;
            end
            else if (busy)
            begin
                if (last_round)
                begin
                    busy       <= 1'b0;
                    done       <= 1'b1;
                    round_cnt  <= '0;
                    // result only lands here, held until the next run ends
                    ciphertext <= round_out;
                end
                else
                begin
                    round_cnt <= round_cnt + 1'b1;
                end
            end
        end
    end

    // initial AddRoundKey on load, one round per cycle after that
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            state_reg <= plaintext ^ key;
        end
        else if (busy)
        begin
            state_reg <= round_out;
        end
    end

    // a new block is never taken in the cycle that reports the last one
    a_no_start_on_done: assert property (@(posedge clk) disable iff (!resetn)
        !(load && done))
        else $error("start accepted in the same cycle as done");

    // counter stays inside 1..10 for the whole run
    a_round_range: assert property (@(posedge clk) disable iff (!resetn)
        busy |-> (round_cnt >= 1) && (round_cnt <= `AES_NUM_ROUNDS))
        else $error("round counter out of range while busy");

endmodule

//--- logic/aes_enc_round.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_enc_round (
    input  aes_state_pkg::state_t   state_in,
    input  aes_key_pkg::round_key_t round_key,
    input  logic                    last_round,
    output aes_state_pkg::state_t   state_out
);

    aes_state_pkg::state_t sub_bytes;
    aes_state_pkg::state_t shifted;
    aes_state_pkg::state_t mixed;
    aes_state_pkg::state_t pre_key;

    // SubBytes on all sixteen bytes at once
    aes_sbox_bank #(
        .num_bytes (`AES_BLOCK_BYTES)
    ) u_sub_bytes (
        .bytes_in  (state_in),
        .bytes_out (sub_bytes)
    );

    // ShiftRows is only wiring
    // row r rotates left by r, so out(r, c) takes in(r, c + r mod 4)
    genvar col;
    genvar row;
    generate
        for (col = 0; col < aes_state_pkg::num_cols; col++)
        begin : g_shift_col
            for (row = 0; row < 4; row++)
            begin : g_shift_row
                assign shifted[`AES_BLOCK_BYTES - 1 - (4*col + row)] =
                    sub_bytes[`AES_BLOCK_BYTES - 1 - (4*((col + row) % 4) + row)];
            end
        end
    endgenerate

    // MixColumns, computed every round
    aes_mix_columns u_mix_columns (
        .state_in  (shifted),
        .state_out (mixed)
    );

    // round 10 skips the column mix
    assign pre_key = last_round ? shifted : mixed;

    // AddRoundKey
    assign state_out = pre_key ^ round_key;

endmodule

//--- logic/aes_key_schedule.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_key_schedule (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    load,
    input  aes_key_pkg::round_key_t key,
    input  logic                    advance,
    output aes_key_pkg::round_key_t round_key
);

    // key for the round last applied, round 0 right after load
    aes_key_pkg::round_key_t key_reg;
    // round constant for the next expansion step
    aes_state_pkg::byte_t    rcon;
    // expansion steps taken since load
    aes_key_pkg::round_idx_t adv_count;

    aes_key_pkg::key_word_t  cur_word [aes_key_pkg::key_words];
    aes_key_pkg::key_word_t  new_word [aes_key_pkg::key_words];
    aes_key_pkg::key_word_t  rot_word;
    aes_key_pkg::key_word_t  sub_word;
    aes_key_pkg::key_word_t  mix_word;

    // split the stored key into w0..w3, w0 in the top bytes
    always_comb
    begin
        for (int i = 0; i < aes_key_pkg::key_words; i++)
        begin
            cur_word[i] = key_reg[`AES_BLOCK_BYTES - 1 - 4*i -: 4];
        end
    end

    // RotWord on w3, first byte moves to the end
    assign rot_word = {cur_word[3][2:0], cur_word[3][3]};

    // SubWord through a four-lane S-box bank
    aes_sbox_bank #(
        .num_bytes (4)
    ) u_sub_word (
        .bytes_in  (rot_word),
        .bytes_out (sub_word)
    );

    // round constant goes into the first byte only
    assign mix_word = sub_word ^ {rcon, 24'h000000};

    // chain through the four words
    always_comb
    begin
        new_word[0] = cur_word[0] ^ mix_word;
        for (int i = 1; i < aes_key_pkg::key_words; i++)
        begin
            new_word[i] = cur_word[i] ^ new_word[i-1];
        end
    end

    // next round key, seen by the round one cycle ahead of the update
    assign round_key = {new_word[0], new_word[1], new_word[2], new_word[3]};

    // control part of the schedule
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            rcon      <= 8'h01;
            adv_count <= '0;
        end
        else if (load)
        begin
            rcon      <= 8'h01;
            adv_count <= '0;
        end
        else if (advance)
        begin
            // rcon doubles in GF(2^8), 80 wraps to 1b
            rcon      <= {rcon[6:0], 1'b0} ^ (rcon[7] ? `AES_GF_REDUCE : 8'h00);
            adv_count <= adv_count + 1'b1;
        end
    end

    // key storage
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            key_reg <= key;
        end
        else if (advance)
        begin
            key_reg <= round_key;
        end
    end

    // core never reloads in the middle of a step
    a_load_advance_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(load && advance))
        else $error("key schedule saw load and advance together");

    // round 10 key is the last one ever needed after a load
    a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
        advance |-> (adv_count < `AES_NUM_ROUNDS - 1))
        else $error("key schedule advanced past the final round key");

endmodule

//--- logic/aes_mix_columns.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_mix_columns (
    input  aes_state_pkg::state_t state_in,
    output aes_state_pkg::state_t state_out
);

    // multiply by x in GF(2^8)
    // shift left, fold the carried-out bit back with the reduction byte
    function automatic aes_state_pkg::byte_t gf_double(input aes_state_pkg::byte_t x);
        aes_state_pkg::byte_t shifted;
        shifted = {x[6:0], 1'b0};
        if (x[7])
        begin
            shifted = shifted ^ `AES_GF_REDUCE;
        end
        return shifted;
    endfunction

    // multiply by x+1, i.e. doubling plus the value itself
    function automatic aes_state_pkg::byte_t gf_triple(input aes_state_pkg::byte_t x);
        return gf_double(x) ^ x;
    endfunction

    // each column times the circulant matrix
    //   2 3 1 1
    //   1 2 3 1
    //   1 1 2 3
    //   3 1 1 2
    genvar col;
    generate
        for (col = 0; col < aes_state_pkg::num_cols; col++)
        begin : g_col
            aes_state_pkg::column_t col_in;
            aes_state_pkg::column_t col_out;
            aes_state_pkg::byte_t a0;
            aes_state_pkg::byte_t a1;
            aes_state_pkg::byte_t a2;
            aes_state_pkg::byte_t a3;

            // column c occupies bytes 15-4c down to 12-4c
            assign col_in = state_in[`AES_BLOCK_BYTES - 1 - 4*col -: 4];

            // rows 0..3, row 0 in the top byte of the column
            assign a0 = col_in[3];
            assign a1 = col_in[2];
            assign a2 = col_in[1];
            assign a3 = col_in[0];

            // row 0
            assign col_out[3] = gf_double(a0) ^ gf_triple(a1) ^ a2 ^ a3;
            // row 1
            assign col_out[2] = a0 ^ gf_double(a1) ^ gf_triple(a2) ^ a3;
            // row 2
            assign col_out[1] = a0 ^ a1 ^ gf_double(a2) ^ gf_triple(a3);
            // row 3
            assign col_out[0] = gf_triple(a0) ^ a1 ^ a2 ^ gf_double(a3);

            // back into the same byte positions
            assign state_out[`AES_BLOCK_BYTES - 1 - 4*col -: 4] = col_out;
        end
    endgenerate

endmodule

//--- logic/aes_sbox_bank.sv
`timescale 1ns/1ps

module aes_sbox_bank #(
    parameter int num_bytes = 16
) (
    input  aes_state_pkg::byte_t [num_bytes-1:0] bytes_in,
    output aes_state_pkg::byte_t [num_bytes-1:0] bytes_out
);

    // forward S-box, entry 0 in the leftmost byte
    // each row covers one high nibble, 16 entries
    localparam logic [0:255][7:0] sbox_rom = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // one independent lookup per byte lane
    // lanes never interact, so the bank is pure fan-out of the table
    genvar lane;
    generate
        for (lane = 0; lane < num_bytes; lane++)
        begin : g_lane
            // byte value selects the table entry directly
            assign bytes_out[lane] = sbox_rom[bytes_in[lane]];
        end
    endgenerate

endmodule

//--- logic/aes_key_pkg.sv
`include "aes_consts.svh"

package aes_key_pkg;

    // key schedule view

    // one 32-bit word w[i] of the expanded key
    // index 3 holds the first byte of the word
    typedef aes_state_pkg::byte_t [3:0] key_word_t;

    // words per round key
    localparam int key_words = 4;

    // round key in the same byte order as the state
    // word 0 sits in bytes 15..12
    typedef aes_state_pkg::byte_t [`AES_BLOCK_BYTES-1:0] round_key_t;

    // round number, 0 when idle, 1 to 10 while a block runs
    typedef logic [3:0] round_idx_t;

endpackage

//--- logic/aes_state_pkg.sv
`include "aes_consts.svh"

package aes_state_pkg;

    // data path view of a block

    // one field element of GF(2^8)
    typedef logic [7:0] byte_t;

    // four bytes of one column
    // index 3 is row 0, index 0 is row 3
    typedef byte_t [3:0] column_t;

    // columns in one state
    localparam int num_cols = 4;

    // full 128-bit block as packed bytes
    // byte 15 is the first byte in FIPS-197 order, byte 0 the last
    // column-major: bytes 15..12 are column 0, 3..0 are column 3
    // so row r of column c lives at index 15 - (4*c + r)
    typedef byte_t [`AES_BLOCK_BYTES-1:0] state_t;

endpackage

//--- include/aes_consts.svh
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// block geometry for AES-128

// bytes in one data block and in one round key
`define AES_BLOCK_BYTES 16

// rounds after the initial AddRoundKey, 128-bit key only
`define AES_NUM_ROUNDS 10

// GF(2^8) reduction
// x^8 = x^4 + x^3 + x + 1, so a doubling that shifts out bit 7
// gets this byte XORed back in
`define AES_GF_REDUCE 8'h1b

`endif
